/* design/codec_cfg_pkg.sv */
package codec_cfg_pkg;

    localparam int NUM_CFG_WORDS  = 7;
    localparam int BYTES_PER_WORD = 3;

    // write address of the codec, r/w bit already zero
    localparam logic [7:0] I2C_DEV_ADDR = 8'h34;

    // device byte, 7-bit register address, 9-bit value
    typedef logic [23:0] cfg_word_t;

    typedef logic [2:0] cfg_index_t;

    // word 0 sits in the top bits and goes out first
    localparam logic [NUM_CFG_WORDS*$bits(cfg_word_t)-1:0] CFG_TABLE = {
        // reset register
        {I2C_DEV_ADDR, 7'h0f, 9'h000},
        // analogue path
        {I2C_DEV_ADDR, 7'h04, 9'h015},
        // digital path
        {I2C_DEV_ADDR, 7'h05, 9'h000},
        // power down control
        {I2C_DEV_ADDR, 7'h06, 9'h000},
        // audio interface format
        {I2C_DEV_ADDR, 7'h07, 9'h042},
        // sampling control
        {I2C_DEV_ADDR, 7'h08, 9'h019},
        // activate interface
        {I2C_DEV_ADDR, 7'h09, 9'h001}
    };

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_ACK,
        S_STARTSTOP
    } init_state_e;

endpackage

/* design/audio_pkg.sv */
package audio_pkg;

    // bits per channel sample
    localparam int SAMPLE_W = 16;

    localparam int FRAME_COUNT_W = 16;

    // two's complement sample from the adc
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // wraps silently
    typedef logic [FRAME_COUNT_W-1:0] frame_count_t;

    typedef logic [$clog2(SAMPLE_W)-1:0] bit_index_t;

endpackage

/* design/sample_if.sv */
`timescale 1ns/100ps

interface sample_if;

    audio_pkg::sample_t data;

    // one cycle per finished sample
    logic valid;

    // high for the right channel
    logic right;

    // sample cut short by an early lrck edge
    logic overrun;

    modport source (
        output data,
        output valid,
        output right,
        output overrun
    );

    modport sink (
        input data,
        input valid,
        input right,
        input overrun
    );

endinterface

/* design/i2c_initializer.sv */
`timescale 1ns/100ps

module i2c_initializer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_ack,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,
    output logic o_finished
);

    codec_cfg_pkg::init_state_e state_r, state_w;
    logic                       sclk_r, sclk_w;
    logic                       sdat_r, sdat_w;
    logic                       oen_r, oen_w;
    logic                       finished_r, finished_w;
    codec_cfg_pkg::cfg_index_t  word_r, word_w;
    logic [1:0]                 byte_r, byte_w;
    logic [2:0]                 bit_r, bit_w;
    codec_cfg_pkg::cfg_word_t   cur_word;
    logic                       cur_bit;
    logic                       last_word;
    logic                       last_byte;

    assign o_sclk     = sclk_r;
    assign o_sdat     = sdat_r;
    assign o_oen      = oen_r;
    assign o_finished = finished_r;

    assign cur_word = codec_cfg_pkg::CFG_TABLE[
        (codec_cfg_pkg::NUM_CFG_WORDS - 1 - word_r) * $bits(codec_cfg_pkg::cfg_word_t)
        +: $bits(codec_cfg_pkg::cfg_word_t)];

    // msb first within the word
    assign cur_bit = cur_word[5'd23 - {byte_r, bit_r}];

    assign last_word = (word_r == codec_cfg_pkg::cfg_index_t'(codec_cfg_pkg::NUM_CFG_WORDS - 1));
    assign last_byte = (byte_r == 2'(codec_cfg_pkg::BYTES_PER_WORD - 1));

    always_comb begin
        state_w    = state_r;
        sclk_w     = sclk_r;
        sdat_w     = sdat_r;
        oen_w      = oen_r;
        finished_w = finished_r;
        word_w     = word_r;
        byte_w     = byte_r;
        bit_w      = bit_r;

        case (state_r)
            codec_cfg_pkg::S_IDLE: begin
                // bus rests with sclk and sdat high
                if (i_start) begin
                    state_w    = codec_cfg_pkg::S_STARTSTOP;
                    sclk_w     = 1'b1;
                    sdat_w     = 1'b1;
                    oen_w      = 1'b1;
                    finished_w = 1'b0;
                    word_w     = '0;
                    byte_w     = '0;
                    bit_w      = '0;
                end
            end

            codec_cfg_pkg::S_STARTSTOP: begin
                if (sdat_r) begin
                    // start, sdat falls under high sclk
                    sdat_w  = 1'b0;
                    state_w = codec_cfg_pkg::S_DATA;
                end else begin
                    // stop, sdat rises under high sclk
                    sdat_w = 1'b1;
                    if (last_word) begin
                        state_w    = codec_cfg_pkg::S_IDLE;
                        finished_w = 1'b1;
                        word_w     = '0;
                    end else begin
                        word_w = word_r + 1'b1;
                    end
                end
            end

            codec_cfg_pkg::S_DATA: begin
                if (sclk_r) begin
                    // low phase, new bit on sdat
                    sclk_w = 1'b0;
                    sdat_w = cur_bit;
                end else begin
                    sclk_w = 1'b1;
                    bit_w  = bit_r + 1'b1;
                    if (bit_r == 3'd7) begin
                        state_w = codec_cfg_pkg::S_ACK;
                    end
                end
            end

            codec_cfg_pkg::S_ACK: begin
                if (sclk_r) begin
                    // hand sdat to the codec
                    sclk_w = 1'b0;
                    oen_w  = 1'b0;
                    sdat_w = 1'b0;
                end else if (!i_ack) begin
                    // ack clock, master takes sdat back low
                    sclk_w = 1'b1;
                    oen_w  = 1'b1;
                    if (last_byte) begin
                        byte_w  = '0;
                        state_w = codec_cfg_pkg::S_STARTSTOP;
                    end else begin
                        byte_w  = byte_r + 1'b1;
                        state_w = codec_cfg_pkg::S_DATA;
                    end
                end
            end

            default: begin
                state_w = codec_cfg_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= codec_cfg_pkg::S_IDLE;
            sclk_r     <= 1'b1;
            sdat_r     <= 1'b1;
            oen_r      <= 1'b1;
            finished_r <= 1'b0;
            word_r     <= '0;
            byte_r     <= '0;
            bit_r      <= '0;
        end else begin
            state_r    <= state_w;
            sclk_r     <= sclk_w;
            sdat_r     <= sdat_w;
            oen_r      <= oen_w;
            finished_r <= finished_w;
            word_r     <= word_w;
            byte_r     <= byte_w;
            bit_r      <= bit_w;
        end
    end

endmodule

/* design/i2s_receiver.sv */
`timescale 1ns/100ps

module i2s_receiver (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_bclk,
    input  logic     i_lrck,
    input  logic     i_adcdat,
    sample_if.source o_smp
);

    logic [1:0]             bclk_s;
    logic [1:0]             lrck_s;
    logic [1:0]             adc_s;
    logic                   bclk_d;
    logic                   lrck_d;
    logic [2:0]             warm_r;
    logic                   bclk_rise;
    logic                   lrck_edge;
    logic                   bit_slot;
    logic                   take_bit;
    logic                   last_bit;
    logic                   word_done;
    logic                   cut_short;
    logic                   active;
    logic                   skip;
    logic                   cur_right;
    logic                   word_right;
    logic                   done_r;
    logic                   ovr_r;
    audio_pkg::bit_index_t  bit_cnt;
    audio_pkg::sample_t     shift_r;

    assign bclk_rise = bclk_s[1] & ~bclk_d;
    // no edges until the synchronizer chain holds real line values
    assign lrck_edge = warm_r[2] & (lrck_s[1] ^ lrck_d);
    assign bit_slot  = bclk_rise & ~lrck_edge;
    assign last_bit  = (bit_cnt == audio_pkg::bit_index_t'(audio_pkg::SAMPLE_W - 1));

    // the delay slot after an lrck edge may still carry the previous lsb
    assign take_bit  = bit_slot & active & (~skip | last_bit);
    assign word_done = take_bit & last_bit;
    assign cut_short = bit_slot & skip & active & ~last_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bclk_s    <= '0;
            lrck_s    <= '0;
            adc_s     <= '0;
            bclk_d    <= 1'b0;
            lrck_d    <= 1'b0;
            warm_r    <= '0;
            active    <= 1'b0;
            skip      <= 1'b0;
            cur_right <= 1'b0;
            bit_cnt   <= '0;
            done_r    <= 1'b0;
            ovr_r     <= 1'b0;
        end else begin
            bclk_s <= {bclk_s[0], i_bclk};
            lrck_s <= {lrck_s[0], i_lrck};
            adc_s  <= {adc_s[0], i_adcdat};
            bclk_d <= bclk_s[1];
            lrck_d <= lrck_s[1];
            warm_r <= {warm_r[1:0], 1'b1};
            done_r <= word_done;
            ovr_r  <= cut_short;

            if (lrck_edge) begin
                skip <= 1'b1;
            end else if (bit_slot) begin
                if (skip) begin
                    // new channel starts after the i2s delay bit
                    skip      <= 1'b0;
                    active    <= 1'b1;
                    bit_cnt   <= '0;
                    cur_right <= lrck_s[1];
                end else if (active) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_bit) begin
            shift_r <= {shift_r[audio_pkg::SAMPLE_W-2:0], adc_s[1]};
        end
        if (word_done) begin
            word_right <= cur_right;
        end
        if (done_r) begin
            o_smp.data  <= shift_r;
            o_smp.right <= word_right;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_smp.valid   <= 1'b0;
            o_smp.overrun <= 1'b0;
        end else begin
            o_smp.valid   <= done_r;
            o_smp.overrun <= ovr_r;
        end
    end

endmodule

/* design/record_controller.sv */
`timescale 1ns/100ps

module record_controller (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_init_done,
    input  logic                    i_record,
    sample_if.sink                  i_smp,
    output audio_pkg::sample_t      o_left,
    output audio_pkg::sample_t      o_right,
    output logic                    o_frame_valid,
    output audio_pkg::frame_count_t o_frame_count,
    output logic                    o_overrun
);

    logic               gate_open;
    logic               accept;
    logic               pair;
    logic               have_left;
    audio_pkg::sample_t left_hold;

    // codec configured and recording requested
    assign gate_open = i_init_done & i_record;
    assign accept    = gate_open & i_smp.valid;

    // right sample completes a frame only behind a stored left
    assign pair = accept & i_smp.right & have_left;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            have_left     <= 1'b0;
            o_frame_valid <= 1'b0;
            o_frame_count <= '0;
            o_overrun     <= 1'b0;
        end else begin
            o_frame_valid <= pair;
            o_overrun     <= i_smp.overrun;

            if (pair) begin
                o_frame_count <= o_frame_count + 1'b1;
            end

            // a stale left never pairs across a gap or a dropped sample
            if (!gate_open || i_smp.overrun) begin
                have_left <= 1'b0;
            end else if (accept) begin
                have_left <= ~i_smp.right;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && !i_smp.right) begin
            left_hold <= i_smp.data;
        end
        if (pair) begin
            o_left  <= left_hold;
            o_right <= i_smp.data;
        end
    end

endmodule

/* design/codec_capture_top.sv */
`timescale 1ns/100ps

module codec_capture_top (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_ack,
    input  logic                    i_bclk,
    input  logic                    i_lrck,
    input  logic                    i_adcdat,
    input  logic                    i_record,
    output logic                    o_sclk,
    output logic                    o_sdat,
    output logic                    o_oen,
    output logic                    o_init_done,
    output audio_pkg::sample_t      o_left,
    output audio_pkg::sample_t      o_right,
    output logic                    o_frame_valid,
    output audio_pkg::frame_count_t o_frame_count,
    output logic                    o_overrun
);

    // receiver to controller
    sample_if smp_if ();

    i2c_initializer u_init (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_ack      (i_ack),
        .o_sclk     (o_sclk),
        .o_sdat     (o_sdat),
        .o_oen      (o_oen),
        .o_finished (o_init_done)
    );

    i2s_receiver u_rx (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_bclk   (i_bclk),
        .i_lrck   (i_lrck),
        .i_adcdat (i_adcdat),
        .o_smp    (smp_if.source)
    );

    record_controller u_rec (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init_done   (o_init_done),
        .i_record      (i_record),
        .i_smp         (smp_if.sink),
        .o_left        (o_left),
        .o_right       (o_right),
        .o_frame_valid (o_frame_valid),
        .o_frame_count (o_frame_count),
        .o_overrun     (o_overrun)
    );

endmodule

/* dv/codec_capture_properties.sv */
`timescale 1ns/100ps

module codec_capture_properties (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input logic                    i_start,
    input logic                    i_ack,
    input logic                    i_record,
    input logic                    o_sclk,
    input logic                    o_sdat,
    input logic                    o_oen,
    input logic                    o_init_done,
    input logic                    o_frame_valid,
    input audio_pkg::frame_count_t o_frame_count
);

    int   assert_errors = 0;
    int   rises;
    logic sclk_q;
    logic sdat_q;
    logic sda_edge_high;

    // sdat moving under a steady high sclk
    assign sda_edge_high = o_sclk & sclk_q & (o_sdat ^ sdat_q);

    // sclk rises since the last start or stop
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sclk_q <= 1'b1;
            sdat_q <= 1'b1;
            rises  <= 0;
        end else begin
            sclk_q <= o_sclk;
            sdat_q <= o_sdat;
            if (sda_edge_high) begin
                rises <= 0;
            end else if (o_sclk && !sclk_q) begin
                rises <= rises + 1;
            end
        end
    end

    // start and stop only on an idle bus or after a whole word of 8 bits plus ack each
    a_start_stop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        sda_edge_high |-> o_oen && (rises == 0 || rises == 9 * codec_cfg_pkg::BYTES_PER_WORD))
        else begin
            $error("sdat changed under high sclk outside a start or stop");
            assert_errors++;
        end

    a_ack_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_oen && i_ack |=> !o_oen && $stable(o_sclk))
        else begin
            $error("bus moved before the codec acknowledged");
            assert_errors++;
        end

    a_done_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_init_done && !i_start |=> o_init_done)
        else begin
            $error("init done fell without a start pulse");
            assert_errors++;
        end

    a_gate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_frame_valid |-> $past(o_init_done && i_record))
        else begin
            $error("frame passed while init was not done or recording was off");
            assert_errors++;
        end

    a_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_frame_valid ? o_frame_count == audio_pkg::frame_count_t'($past(o_frame_count) + 1)
                      : $stable(o_frame_count))
        else begin
            $error("frame count does not follow the frame pulses");
            assert_errors++;
        end

endmodule

bind codec_capture_top codec_capture_properties u_props (.*);

/* dv/codec_capture_tb.sv */
`timescale 1ns/100ps

module codec_capture_tb;

    localparam int BCLK_HALF    = 4;
    localparam int WORD_CYCLES  = 2 + codec_cfg_pkg::BYTES_PER_WORD * (2 * 9 + 5);
    localparam int FRAME_CYCLES = 2 * (audio_pkg::SAMPLE_W + 1) * 2 * BCLK_HALF;
    // two init runs plus twelve frames and the gaps behind them, doubled
    localparam int RUN_LIMIT    = 2 * (2 * codec_cfg_pkg::NUM_CFG_WORDS * WORD_CYCLES
                                       + 12 * (FRAME_CYCLES + 16));

    logic i_clk, i_rst_n, i_start, i_ack, i_bclk, i_lrck, i_adcdat, i_record;
    logic o_sclk, o_sdat, o_oen, o_init_done, o_frame_valid, o_overrun;
    audio_pkg::sample_t      o_left, o_right;
    audio_pkg::frame_count_t o_frame_count;

    integer      seed = 32'h880a_9a87;
    int          errors, tests_run, tests_failed, cycles, mark;
    int          bit_pos, byte_idx, bytes_seen, frames_seen, overrun_seen;
    logic        prev_sclk, prev_sdat, released;
    logic [7:0]  rx_byte;
    logic [31:0] expected[$];
    logic [31:0] exp_pair;

    codec_capture_top u_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < RUN_LIMIT) begin
            @(negedge i_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
        $display("Regression failed");
        $finish;
    end

    // codec pulls ack low a few cycles after the bus is released
    initial begin
        i_ack = 1'b1;
        forever begin
            @(negedge i_clk);
            if (i_rst_n && !o_oen) begin
                repeat (($random(seed) & 32'h7fff_ffff) % 6) @(negedge i_clk);
                i_ack = 1'b0;
                while (!o_oen) @(negedge i_clk);
                i_ack = 1'b1;
            end
        end
    end

    function automatic int total_errors();
        return errors + u_dut.u_props.assert_errors;
    endfunction

    task automatic check_byte(input logic [7:0] got);
        codec_cfg_pkg::cfg_word_t word;
        logic [7:0]               want;
        word = codec_cfg_pkg::CFG_TABLE[(codec_cfg_pkg::NUM_CFG_WORDS - 1
                - byte_idx / codec_cfg_pkg::BYTES_PER_WORD) * 24 +: 24];
        want = word[(2 - byte_idx % codec_cfg_pkg::BYTES_PER_WORD) * 8 +: 8];
        if (got !== want) begin
            $display("CHECK FAILED o_sdat byte %0d: expected %h, got %h", byte_idx, want, got);
            errors++;
        end
        if (byte_idx % codec_cfg_pkg::BYTES_PER_WORD == 0
                && got !== codec_cfg_pkg::I2C_DEV_ADDR) begin
            $display("CHECK FAILED o_sdat address: expected %h, got %h",
                     codec_cfg_pkg::I2C_DEV_ADDR, got);
            errors++;
        end
        bytes_seen++;
        byte_idx = (byte_idx == 3 * codec_cfg_pkg::NUM_CFG_WORDS - 1) ? 0 : byte_idx + 1;
    endtask

    // bytes rebuilt from sdat on sclk rises
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (prev_sclk && o_sclk && prev_sdat && !o_sdat) begin
                bit_pos = 0;
            end else if (!prev_sclk && o_sclk) begin
                rx_byte = (bit_pos < 8) ? {rx_byte[6:0], o_sdat} : rx_byte;
                bit_pos++;
                if (bit_pos == 8) begin
                    check_byte(rx_byte);
                end else if (bit_pos == 9) begin
                    // ninth rise is the ack clock
                    if (!released) begin
                        $display("bus was not released for the acknowledge of byte %0d", byte_idx);
                        errors++;
                    end
                    bit_pos  = 0;
                    released = 1'b0;
                end
            end
            if (!o_oen) begin
                released = 1'b1;
            end
        end
        prev_sclk = o_sclk;
        prev_sdat = o_sdat;
    end

    always @(negedge i_clk) begin
        if (i_rst_n && o_overrun) begin
            overrun_seen++;
        end
        if (i_rst_n && o_frame_valid) begin
            frames_seen++;
            if (expected.size() == 0) begin
                $display("frame appeared with no matching pair sent while recording");
                errors++;
            end else begin
                exp_pair = expected.pop_front();
                if (o_left !== exp_pair[31:16]) begin
                    $display("CHECK FAILED o_left: expected %h, got %h", exp_pair[31:16], o_left);
                    errors++;
                end
                if (o_right !== exp_pair[15:0]) begin
                    $display("CHECK FAILED o_right: expected %h, got %h", exp_pair[15:0], o_right);
                    errors++;
                end
            end
            if (o_frame_count !== audio_pkg::frame_count_t'(frames_seen)) begin
                $display("CHECK FAILED o_frame_count: expected %h, got %h",
                         audio_pkg::frame_count_t'(frames_seen), o_frame_count);
                errors++;
            end
        end
    end

    // one bclk period with data and lrck set on the falling edge
    task automatic bclk_slot(input logic lr, input logic bit_val);
        i_bclk   = 1'b0;
        i_lrck   = lr;
        i_adcdat = bit_val;
        repeat (BCLK_HALF) @(negedge i_clk);
        i_bclk = 1'b1;
        repeat (BCLK_HALF) @(negedge i_clk);
    endtask

    task automatic send_frame(input audio_pkg::sample_t l, input audio_pkg::sample_t r,
                              input int left_bits);
        bclk_slot(1'b0, 1'b0);
        for (int i = 0; i < left_bits; i++) begin
            bclk_slot(1'b0, l[audio_pkg::SAMPLE_W-1-i]);
        end
        bclk_slot(1'b1, 1'b0);
        for (int i = 0; i < audio_pkg::SAMPLE_W; i++) begin
            bclk_slot(1'b1, r[audio_pkg::SAMPLE_W-1-i]);
        end
    endtask

    task automatic send_random(input int n, input bit expect_frames);
        audio_pkg::sample_t l;
        audio_pkg::sample_t r;
        for (int i = 0; i < n; i++) begin
            l = audio_pkg::sample_t'($random(seed));
            r = audio_pkg::sample_t'($random(seed));
            if (expect_frames) begin
                expected.push_back({l, r});
            end
            send_frame(l, r, audio_pkg::SAMPLE_W);
        end
        repeat (16) @(negedge i_clk);
    endtask

    task automatic run_init(input int want_bytes);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        if (o_init_done !== 1'b0) begin
            $display("CHECK FAILED o_init_done after start: expected %h, got %h",
                     1'b0, o_init_done);
            errors++;
        end
        while (!o_init_done) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        if (bytes_seen != want_bytes) begin
            $display("init ended after %0d bytes instead of %0d", bytes_seen, want_bytes);
            errors++;
        end
        if ({o_sclk, o_sdat} !== 2'b11) begin
            $display("CHECK FAILED o_sclk/o_sdat idle: expected %h, got %h",
                     2'b11, {o_sclk, o_sdat});
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_errors() != mark) begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
        mark = total_errors();
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_bclk    = 1'b0;
        i_lrck    = 1'b1;
        i_adcdat  = 1'b0;
        i_record  = 1'b1;
        prev_sclk = 1'b1;
        prev_sdat = 1'b1;
        released  = 1'b0;
        mark      = 0;
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;

        send_random(2, 1'b0);
        finish_test("gated before init");

        run_init(3 * codec_cfg_pkg::NUM_CFG_WORDS);
        finish_test("init sequence");

        run_init(6 * codec_cfg_pkg::NUM_CFG_WORDS);
        finish_test("restart");

        i_record = 1'b0;
        send_random(2, 1'b0);
        finish_test("gated by record");

        i_record = 1'b1;
        send_random(6, 1'b1);
        if (frames_seen != 6 || expected.size() != 0) begin
            $display("saw %0d frames, %0d still expected", frames_seen, expected.size());
            errors++;
        end
        finish_test("frames");

        // left sample cut after 10 bits
        send_frame(audio_pkg::sample_t'($random(seed)), audio_pkg::sample_t'($random(seed)), 10);
        send_random(1, 1'b1);
        if (overrun_seen != 1 || expected.size() != 0 || frames_seen != 7) begin
            $display("cut sample gave %0d overruns and %0d frames", overrun_seen, frames_seen);
            errors++;
        end
        finish_test("overrun");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* codec_capture.f */
design/codec_cfg_pkg.sv
design/audio_pkg.sv
design/sample_if.sv
design/i2c_initializer.sv
design/i2s_receiver.sv
design/record_controller.sv
design/codec_capture_top.sv
dv/codec_capture_properties.sv
dv/codec_capture_tb.sv
